// File: tb/reorder_golden.txt
// valid data kind acc_start relu layer_finish acc_para slice_finish
// one line per clock cycle, tag columns are zero on idle cycles
1 00a55a00c33c00f00f00966900123400 0 1 1 0 2 0
1 01a55a01c33c01f00f01966901123401 0 0 1 0 2 0
1 02a55a02c33c02f00f02966902123402 0 0 1 0 2 0
1 03a55a03c33c03f00f03966903123403 0 1 1 0 2 0
1 04a55a04c33c04f00f04966904123404 0 0 1 0 2 0
0 05a55a05c33c05f00f05966905123405 0 0 0 0 0 0
1 06a55a06c33c06f00f06966906123406 0 0 1 0 2 0
1 07a55a07c33c07f00f07966907123407 0 1 1 0 2 0
1 08a55a08c33c08f00f08966908123408 0 0 1 0 2 0
1 09a55a09c33c09f00f09966909123409 0 0 1 0 2 0
1 0aa55a0ac33c0af00f0a96690a12340a 0 1 1 0 2 0
1 0ba55a0bc33c0bf00f0b96690b12340b 0 0 1 0 2 0
1 0ca55a0cc33c0cf00f0c96690c12340c 0 0 1 1 2 1
0 0da55a0dc33c0df00f0d96690d12340d 0 0 0 0 0 0
1 0ea55a0ec33c0ef00f0e96690e12340e 1 1 1 0 0 0
1 0fa55a0fc33c0ff00f0f96690f12340f 1 0 1 0 0 0
1 10a55a10c33c10f00f10966910123410 1 0 1 0 0 0
1 11a55a11c33c11f00f11966911123411 1 1 1 0 0 0
1 12a55a12c33c12f00f12966912123412 1 0 1 0 0 0
1 13a55a13c33c13f00f13966913123413 1 0 1 0 0 0
1 14a55a14c33c14f00f14966914123414 1 1 1 0 0 0
1 15a55a15c33c15f00f15966915123415 1 0 1 0 0 0
0 16a55a16c33c16f00f16966916123416 0 0 0 0 0 0
1 17a55a17c33c17f00f17966917123417 1 0 1 0 0 0
1 18a55a18c33c18f00f18966918123418 1 1 1 0 0 0
1 19a55a19c33c19f00f19966919123419 1 0 1 0 0 0
1 1aa55a1ac33c1af00f1a96691a12341a 1 0 1 1 0 1
1 1ba55a1bc33c1bf00f1b96691b12341b 2 1 0 0 1 0
1 1ca55a1cc33c1cf00f1c96691c12341c 2 0 0 0 1 0
1 1da55a1dc33c1df00f1d96691d12341d 2 1 0 0 1 0
1 1ea55a1ec33c1ef00f1e96691e12341e 2 0 0 0 1 0
1 1fa55a1fc33c1ff00f1f96691f12341f 2 1 0 0 1 0
1 20a55a20c33c20f00f20966920123420 2 0 0 0 1 0
0 21a55a21c33c21f00f21966921123421 0 0 0 0 0 0
0 22a55a22c33c22f00f22966922123422 0 0 0 0 0 0
1 23a55a23c33c23f00f23966923123423 2 1 0 0 1 0
1 24a55a24c33c24f00f24966924123424 2 0 0 0 1 1
1 25a55a25c33c25f00f25966925123425 2 1 0 0 1 0
1 26a55a26c33c26f00f26966926123426 2 0 0 0 1 0
1 27a55a27c33c27f00f27966927123427 2 1 0 0 1 0
1 28a55a28c33c28f00f28966928123428 2 0 0 0 1 0
1 29a55a29c33c29f00f29966929123429 2 1 0 0 1 0
0 2aa55a2ac33c2af00f2a96692a12342a 0 0 0 0 0 0
1 2ba55a2bc33c2bf00f2b96692b12342b 2 0 0 0 1 0
1 2ca55a2cc33c2cf00f2c96692c12342c 2 1 0 0 1 0
1 2da55a2dc33c2df00f2d96692d12342d 2 0 0 1 1 1
1 2ea55a2ec33c2ef00f2e96692e12342e 0 1 1 0 2 0
1 2fa55a2fc33c2ff00f2f96692f12342f 0 0 1 0 2 0

// File: files.f
hw/reorder_pkg.sv
hw/layer_if.sv
hw/layer_sequencer.sv
hw/beat_counter.sv
hw/fifo_word_builder.sv
hw/reorder_top.sv
tb/tb_reorder_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_reorder_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^RESULT: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_reorder_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reorder_top
    import reorder_pkg::*;
();

    localparam int LANES        = 16;
    localparam int ELEM_W       = 8;
    localparam int DATA_W       = LANES * ELEM_W;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int GOLDEN_LINES = 48;
    localparam int GOLDEN_COLS  = 8;
    localparam int LATENCY      = 3;

    typedef struct packed {
        logic [31:0]       due;
        logic [DATA_W-1:0] data;
        fifo_tag_t         tag;
    } expect_t;

    logic              clk_data;
    logic              rst_n;
    logic              data_valid_i;
    logic [DATA_W-1:0] data_i;
    logic              fifo_wr_en_o;
    logic [DATA_W-1:0] fifo_wr_data_o;
    fifo_tag_t         fifo_wr_tag_o;

    // each line holds valid, data and the six tag fields
    logic [DATA_W-1:0] golden_mem [GOLDEN_LINES*GOLDEN_COLS];
    expect_t           exp_q [$];
    logic [31:0]       cycle = '0;
    int                error_count = 0;
    int                check_count = 0;

    reorder_top #(
        .LANES  (LANES),
        .ELEM_W (ELEM_W)
    ) i_dut (
        .clk_data       (clk_data),
        .rst_n          (rst_n),
        .data_valid_i   (data_valid_i),
        .data_i         (data_i),
        .fifo_wr_en_o   (fifo_wr_en_o),
        .fifo_wr_data_o (fifo_wr_data_o),
        .fifo_wr_tag_o  (fifo_wr_tag_o)
    );

    initial begin
        clk_data = 1'b0;
        forever #(CLK_PERIOD / 2) clk_data = ~clk_data;
    end

    always @(posedge clk_data) begin
        cycle <= cycle + 32'd1;
    end

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // output monitor sampled mid cycle
    // ------------------------------------------------------------
    always @(negedge clk_data) begin : monitor
        logic    expect_write;
        expect_t entry;
        expect_write = (exp_q.size() > 0) && (exp_q[0].due == cycle);
        check_value("fifo_wr_en_o", DATA_W'(fifo_wr_en_o), DATA_W'(expect_write));
        if (expect_write) begin
            entry = exp_q.pop_front();
            check_value("fifo_wr_data_o", fifo_wr_data_o, entry.data);
            check_value("tag kind", DATA_W'(fifo_wr_tag_o.kind), DATA_W'(entry.tag.kind));
            check_value("tag acc_start", DATA_W'(fifo_wr_tag_o.acc_start),
                        DATA_W'(entry.tag.acc_start));
            check_value("tag relu", DATA_W'(fifo_wr_tag_o.relu), DATA_W'(entry.tag.relu));
            check_value("tag layer_finish", DATA_W'(fifo_wr_tag_o.layer_finish),
                        DATA_W'(entry.tag.layer_finish));
            check_value("tag acc_para", DATA_W'(fifo_wr_tag_o.acc_para),
                        DATA_W'(entry.tag.acc_para));
            check_value("tag slice_finish", DATA_W'(fifo_wr_tag_o.slice_finish),
                        DATA_W'(entry.tag.slice_finish));
        end else begin
            // idle cycles leave the write word cleared
            check_value("idle fifo_wr_data_o", fifo_wr_data_o, '0);
            check_value("idle fifo_wr_tag_o", DATA_W'(fifo_wr_tag_o), '0);
        end
    end

    // ------------------------------------------------------------
    // golden replay
    // ------------------------------------------------------------
    initial begin : replay
        int      base;
        int      bad_entries;
        expect_t entry;
        rst_n        = 1'b0;
        data_valid_i = 1'b0;
        data_i       = '0;
        bad_entries  = 0;
        $readmemh("tb/reorder_golden.txt", golden_mem);
        for (int i = 0; i < GOLDEN_LINES * GOLDEN_COLS; i++) begin
            if ($isunknown(golden_mem[i])) begin
                bad_entries++;
            end
        end
        if (bad_entries != 0) begin
            error_count++;
            $display("The golden file tb/reorder_golden.txt is missing or short (%0d entries).",
                     bad_entries);
        end

        repeat (RESET_CYCLES) @(posedge clk_data);
        #1 rst_n = 1'b1;

        for (int line = 0; line < GOLDEN_LINES; line++) begin
            @(posedge clk_data);
            #1;
            base         = line * GOLDEN_COLS;
            data_valid_i = golden_mem[base][0];
            data_i       = golden_mem[base + 1];
            if (data_valid_i) begin
                entry.due              = cycle + 32'(LATENCY);
                entry.data             = golden_mem[base + 1];
                entry.tag.kind         = layer_kind_t'(golden_mem[base + 2][1:0]);
                entry.tag.acc_start    = golden_mem[base + 3][0];
                entry.tag.relu         = golden_mem[base + 4][0];
                entry.tag.layer_finish = golden_mem[base + 5][0];
                entry.tag.acc_para     = golden_mem[base + 6][6:0];
                entry.tag.slice_finish = golden_mem[base + 7][0];
                exp_q.push_back(entry);
            end
        end

        @(posedge clk_data);
        #1;
        data_valid_i = 1'b0;
        data_i       = '0;

        // drain the pipeline
        while (exp_q.size() != 0) begin
            @(posedge clk_data);
        end
        repeat (2) @(posedge clk_data);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((GOLDEN_LINES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns, %0d writes still expected.",
                 (GOLDEN_LINES + 20) * CLK_PERIOD, exp_q.size());
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/reorder_top.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_top
    import reorder_pkg::*;
#(
    parameter int LANES  = 16,
    parameter int ELEM_W = 8
) (
    input  logic                      clk_data,
    input  logic                      rst_n,
    input  logic                      data_valid_i,
    input  logic [LANES*ELEM_W-1:0]   data_i,
    output logic                      fifo_wr_en_o,
    output logic [LANES*ELEM_W-1:0]   fifo_wr_data_o,
    output fifo_tag_t                 fifo_wr_tag_o
);

    layer_ctrl_if i_ctrl ();
    beat_pos_if   i_pos ();

    layer_sequencer i_seq (
        .clk_data (clk_data),
        .rst_n    (rst_n),
        .ctrl_o   (i_ctrl.seq),
        .pos_i    (i_pos.seq)
    );

    beat_counter i_cnt (
        .clk_data     (clk_data),
        .rst_n        (rst_n),
        .data_valid_i (data_valid_i),
        .ctrl_i       (i_ctrl.cnt),
        .pos_o        (i_pos.cnt)
    );

    // tag and data leave three cycles after the beat
    fifo_word_builder #(
        .LANES  (LANES),
        .ELEM_W (ELEM_W)
    ) i_bld (
        .clk_data       (clk_data),
        .rst_n          (rst_n),
        .data_i         (data_i),
        .ctrl_i         (i_ctrl.bld),
        .pos_i          (i_pos.bld),
        .fifo_wr_en_o   (fifo_wr_en_o),
        .fifo_wr_data_o (fifo_wr_data_o),
        .fifo_wr_tag_o  (fifo_wr_tag_o)
    );

endmodule

`default_nettype wire

// File: hw/fifo_word_builder.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_word_builder
    import reorder_pkg::*;
#(
    parameter int LANES  = 16,
    parameter int ELEM_W = 8
) (
    input  logic                      clk_data,
    input  logic                      rst_n,
    input  logic [LANES*ELEM_W-1:0]   data_i,
    layer_ctrl_if.bld                 ctrl_i,
    beat_pos_if.bld                   pos_i,
    output logic                      fifo_wr_en_o,
    output logic [LANES*ELEM_W-1:0]   fifo_wr_data_o,
    output fifo_tag_t                 fifo_wr_tag_o
);

    localparam int DATA_W = LANES * ELEM_W;

    fifo_tag_t          tag_new;
    fifo_tag_t          tag_s1;
    fifo_tag_t          tag_s2;
    fifo_tag_t          tag_s3;
    logic [2:0]         vld_q;
    logic [DATA_W-1:0]  data_s1;
    logic [DATA_W-1:0]  data_s2;
    logic [DATA_W-1:0]  data_s3;

    // ------------------------------------------------------------
    // stage 1 tag
    // ------------------------------------------------------------
    always_comb begin
        tag_new.kind         = ctrl_i.kind;
        tag_new.relu         = ctrl_i.relu;
        tag_new.acc_start    = pos_i.acc_start;
        tag_new.slice_finish = pos_i.slice_last;
        tag_new.layer_finish = pos_i.layer_last;
        // dw accumulates nothing across beats
        tag_new.acc_para     = (ctrl_i.kind == LAYER_DW) ? 7'd0 : 7'(ctrl_i.inner_max);
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= '0;
            tag_s1 <= '0;
            tag_s2 <= '0;
            tag_s3 <= '0;
        end else begin
            vld_q  <= {vld_q[1:0], pos_i.beat};
            tag_s1 <= pos_i.beat ? tag_new : '0;
            tag_s2 <= tag_s1;
            tag_s3 <= tag_s2;
        end
    end

    // ------------------------------------------------------------
    // data alignment, same depth as the tag
    // ------------------------------------------------------------
    always_ff @(posedge clk_data) begin
        data_s1 <= data_i;
        data_s2 <= data_s1;
        data_s3 <= data_s2;
    end

    assign fifo_wr_en_o   = vld_q[2];
    assign fifo_wr_data_o = vld_q[2] ? data_s3 : '0;
    assign fifo_wr_tag_o  = tag_s3;

    a_finish_order: assert property (@(posedge clk_data) disable iff (!rst_n)
        fifo_wr_tag_o.layer_finish |-> fifo_wr_tag_o.slice_finish && fifo_wr_en_o);

endmodule

`default_nettype wire

// File: hw/beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beat_counter
    import reorder_pkg::*;
(
    input  logic           clk_data,
    input  logic           rst_n,
    input  logic           data_valid_i,
    layer_ctrl_if.cnt      ctrl_i,
    beat_pos_if.cnt        pos_o
);

    // ------------------------------------------------------------
    // nested position counters
    // ------------------------------------------------------------
    logic [CNT_W-1:0] inner_cnt;
    logic [CNT_W-1:0] col_cnt;
    logic [CNT_W-1:0] row_cnt;
    logic [CNT_W-1:0] grp_cnt;

    logic inner_wrap;
    logic col_wrap;
    logic row_wrap;
    logic grp_wrap;

    // carry chain, each level wraps only when all below do
    assign inner_wrap = (inner_cnt == ctrl_i.inner_max);
    assign col_wrap   = inner_wrap && (col_cnt == ctrl_i.col_max);
    assign row_wrap   = col_wrap && (row_cnt == ctrl_i.row_max);
    assign grp_wrap   = row_wrap && (grp_cnt == ctrl_i.group_max);

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            inner_cnt <= '0;
        end else if (data_valid_i) begin
            inner_cnt <= inner_wrap ? '0 : inner_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
        end else if (data_valid_i && inner_wrap) begin
            col_cnt <= col_wrap ? '0 : col_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (data_valid_i && col_wrap) begin
            row_cnt <= row_wrap ? '0 : row_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            grp_cnt <= '0;
        end else if (data_valid_i && row_wrap) begin
            grp_cnt <= grp_wrap ? '0 : grp_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // position markers
    // ------------------------------------------------------------
    assign pos_o.beat       = data_valid_i;
    assign pos_o.acc_start  = (inner_cnt == '0);
    assign pos_o.slice_last = row_wrap;
    assign pos_o.layer_last = grp_wrap;

    a_last_in_slice: assert property (@(posedge clk_data) disable iff (!rst_n)
        pos_o.layer_last |-> pos_o.slice_last);

    // limits only change when all counters are back at zero
    a_cnt_in_range: assert property (@(posedge clk_data) disable iff (!rst_n)
        (inner_cnt <= ctrl_i.inner_max) && (col_cnt <= ctrl_i.col_max)
        && (row_cnt <= ctrl_i.row_max) && (grp_cnt <= ctrl_i.group_max));

endmodule

`default_nettype wire

// File: hw/layer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer
    import reorder_pkg::*;
(
    input  logic           clk_data,
    input  logic           rst_n,
    layer_ctrl_if.seq      ctrl_o,
    beat_pos_if.seq        pos_i
);

    localparam int IDX_W = (NET_LAYERS > 1) ? $clog2(NET_LAYERS) : 1;

    localparam logic [CNT_W:0] GRP_ROUND = (CNT_W+1)'(CH_GROUP - 1);
    localparam logic [CNT_W:0] GRP_DIV   = (CNT_W+1)'(CH_GROUP);

    logic [IDX_W-1:0] layer_idx;
    logic [IDX_W-1:0] next_idx;
    logic             advance;
    layer_cfg_t       next_cfg;

    // ceil(ch / CH_GROUP) - 1
    function automatic logic [CNT_W-1:0] group_limit(input logic [CNT_W-1:0] ch);
        logic [CNT_W:0] groups;
        groups = ({1'b0, ch} + GRP_ROUND) / GRP_DIV;
        return CNT_W'(groups - 1'b1);
    endfunction

    // taps for conv and dw, input channel groups for pw
    function automatic logic [CNT_W-1:0] inner_limit(input layer_cfg_t cfg);
        logic [CNT_W-1:0] lim;
        case (cfg.kind)
            LAYER_CONV: lim = CNT_W'(CONV_TAPS - 1);
            LAYER_DW:   lim = CNT_W'(DW_TAPS - 1);
            default:    lim = group_limit(cfg.ch_in);
        endcase
        return lim;
    endfunction

    assign advance  = pos_i.beat && pos_i.layer_last;
    assign next_idx = (layer_idx == IDX_W'(NET_LAYERS - 1)) ? '0 : layer_idx + 1'b1;
    assign next_cfg = NET_CFG[next_idx];

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            layer_idx        <= '0;
            ctrl_o.kind      <= NET_CFG[0].kind;
            ctrl_o.relu      <= NET_CFG[0].relu;
            ctrl_o.inner_max <= inner_limit(NET_CFG[0]);
            ctrl_o.col_max   <= CNT_W'(NET_CFG[0].pic_size) - 1'b1;
            ctrl_o.row_max   <= CNT_W'(NET_CFG[0].pic_size) - 1'b1;
            ctrl_o.group_max <= group_limit(NET_CFG[0].ch_out);
        end else if (advance) begin
            layer_idx        <= next_idx;
            ctrl_o.kind      <= next_cfg.kind;
            ctrl_o.relu      <= next_cfg.relu;
            ctrl_o.inner_max <= inner_limit(next_cfg);
            ctrl_o.col_max   <= CNT_W'(next_cfg.pic_size) - 1'b1;
            ctrl_o.row_max   <= CNT_W'(next_cfg.pic_size) - 1'b1;
            ctrl_o.group_max <= group_limit(next_cfg.ch_out);
        end
    end

    a_idx_range: assert property (@(posedge clk_data) disable iff (!rst_n)
        layer_idx < IDX_W'(NET_LAYERS));

endmodule

`default_nettype wire

// File: hw/layer_if.sv
`timescale 1ns/1ps
`default_nettype none

// limits of the current layer, stable for the whole layer
interface layer_ctrl_if
    import reorder_pkg::*;
();
    layer_kind_t      kind;
    logic             relu;
    logic [CNT_W-1:0] inner_max;
    logic [CNT_W-1:0] col_max;
    logic [CNT_W-1:0] row_max;
    logic [CNT_W-1:0] group_max;

    modport seq (output kind, relu, inner_max, col_max, row_max, group_max);
    modport cnt (input inner_max, col_max, row_max, group_max);
    modport bld (input kind, relu, inner_max);
endinterface

// position of the beat in this cycle
interface beat_pos_if;
    logic beat;
    logic acc_start;
    logic slice_last;
    logic layer_last;

    modport cnt (output beat, acc_start, slice_last, layer_last);
    modport seq (input beat, layer_last);
    modport bld (input beat, acc_start, slice_last, layer_last);
endinterface

`default_nettype wire

// File: hw/reorder_pkg.sv
`default_nettype none

package reorder_pkg;

    // ------------------------------------------------------------
    // layer description
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        LAYER_CONV = 2'd0,
        LAYER_DW   = 2'd1,
        LAYER_PW   = 2'd2
    } layer_kind_t;

    typedef struct packed {
        layer_kind_t kind;
        logic [7:0]  pic_size;
        logic [10:0] ch_in;
        logic [10:0] ch_out;
        logic        relu;
    } layer_cfg_t;

    localparam int NET_LAYERS = 3;

    // walked in order, wraps to layer 0
    localparam layer_cfg_t NET_CFG [NET_LAYERS] = '{
        '{kind: LAYER_CONV, pic_size: 8'd2, ch_in: 11'd3,  ch_out: 11'd16, relu: 1'b1},
        '{kind: LAYER_DW,   pic_size: 8'd2, ch_in: 11'd16, ch_out: 11'd16, relu: 1'b1},
        '{kind: LAYER_PW,   pic_size: 8'd2, ch_in: 11'd32, ch_out: 11'd32, relu: 1'b0}
    };

    localparam int CH_GROUP  = 16;
    localparam int CONV_TAPS = 3;
    localparam int DW_TAPS   = 3;
    localparam int CNT_W     = 11;

    // ------------------------------------------------------------
    // sideband tag next to each fifo word
    // ------------------------------------------------------------
    typedef struct packed {
        layer_kind_t kind;
        logic        acc_start;
        logic        relu;
        logic        layer_finish;
        logic [6:0]  acc_para;
        logic        slice_finish;
    } fifo_tag_t;

endpackage

`default_nettype wire
